//--- hw/command_dispatch.sv
/* Opcode decoder that routes parameter bytes to the fill command and flags unknown opcodes */
module command_dispatch (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] data_in,
    input  logic       data_valid,
    input  logic       fill_ready,
    input  logic       fill_done,
    output logic       cmd_enable,
    output logic       ready,
    output logic       cmd_error
);
    led_pkg::dispatch_state_t state;

    // While waiting for an opcode the dispatcher itself is always ready
    always_comb begin
        if (state == led_pkg::STATE_FORWARD) begin
            ready = fill_ready;
            cmd_enable = data_valid && fill_ready; // Strobes during busy are dropped
        end else begin
            ready = 1'b1;
            cmd_enable = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= led_pkg::STATE_OPCODE;
            cmd_error <= 1'b0;
        end else begin
            cmd_error <= 1'b0;
            case (state)
                led_pkg::STATE_OPCODE: begin
                    if (data_valid) begin
                        if (data_in == led_pkg::OP_FILLRECT) begin
                            state <= led_pkg::STATE_FORWARD;
                        end else if (data_in != led_pkg::OP_NOP) begin
                            cmd_error <= 1'b1; // Unknown opcode, stay put
                        end
                    end
                end
                led_pkg::STATE_FORWARD: begin
                    if (fill_done) begin
                        state <= led_pkg::STATE_OPCODE;
                    end
                end
                default: state <= led_pkg::STATE_OPCODE;
            endcase
        end
    end
endmodule

//--- hw/control_cmd_fillrect.sv
/* Fill-rectangle command: captures x1, y1, width, height and colour, then runs the fill engine */
module control_cmd_fillrect #(
    parameter int PIXEL_WIDTH = led_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT = led_pkg::PIXEL_HEIGHT,
    parameter int BYTES_PER_PIXEL = led_pkg::BYTES_PER_PIXEL
) (
    input  logic clk,
    input  logic reset,
    input  logic [7:0] data_in,
    input  logic enable,
    output logic [led_pkg::num_row_address_bits(PIXEL_HEIGHT)-1:0] row,
    output logic [led_pkg::num_column_address_bits(PIXEL_WIDTH)-1:0] column,
    output logic [led_pkg::num_pixel_select_bits(BYTES_PER_PIXEL)-1:0] pixel,
    output logic [7:0] data_out,
    output logic ram_write_enable,
    output logic ready_for_data,
    output logic done
);
    localparam int COLUMN_BITS = led_pkg::num_column_address_bits(PIXEL_WIDTH);
    localparam int COLUMN_BYTES = led_pkg::num_bytes_to_contain(COLUMN_BITS + 1);
    localparam int COUNT_BITS = (COLUMN_BYTES > 1) ? $clog2(COLUMN_BYTES) : 1;
    localparam int SEL_BITS = led_pkg::num_pixel_select_bits(BYTES_PER_PIXEL);

    typedef enum logic [3:0] {
        STATE_X1,
        STATE_Y1,
        STATE_WIDTH,
        STATE_HEIGHT,
        STATE_COLOR,
        STATE_START,
        STATE_RUNNING,
        STATE_PREDONE,
        STATE_DONE
    } fillrect_state_t;

    fillrect_state_t state;
    logic [COLUMN_BYTES*8-1:0] x1;
    logic [COLUMN_BYTES*8-1:0] width;
    logic [7:0] y1;
    logic [7:0] height;
    logic [BYTES_PER_PIXEL*8-1:0] color;
    logic [COUNT_BITS-1:0] x1_count;
    logic [COUNT_BITS-1:0] width_count;
    logic [SEL_BITS-1:0] color_count;
    logic fill_enable;
    logic fill_done;
    logic local_reset;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= STATE_X1;
            ready_for_data <= 1'b1;
            done <= 1'b0;
            fill_enable <= 1'b0;
            local_reset <= 1'b0;
            x1_count <= COUNT_BITS'(COLUMN_BYTES - 1);
            width_count <= COUNT_BITS'(COLUMN_BYTES - 1);
            color_count <= SEL_BITS'(BYTES_PER_PIXEL - 1);
        end else begin
            case (state)
                STATE_X1: begin
                    if (enable) begin
                        x1[x1_count*8 +: 8] <= data_in; // Most significant byte arrives first
                        if (x1_count == '0) state <= STATE_Y1;
                        else x1_count <= x1_count - 1'b1;
                    end
                end
                STATE_Y1: begin
                    if (enable) begin
                        y1 <= data_in;
                        state <= STATE_WIDTH;
                    end
                end
                STATE_WIDTH: begin
                    if (enable) begin
                        width[width_count*8 +: 8] <= data_in;
                        if (width_count == '0) state <= STATE_HEIGHT;
                        else width_count <= width_count - 1'b1;
                    end
                end
                STATE_HEIGHT: begin
                    if (enable) begin
                        height <= data_in;
                        state <= STATE_COLOR;
                    end
                end
                STATE_COLOR: begin
                    if (enable) begin
                        color[color_count*8 +: 8] <= data_in;
                        if (color_count == '0) begin
                            state <= STATE_START;
                            ready_for_data <= 1'b0;
                        end else begin
                            color_count <= color_count - 1'b1;
                        end
                    end
                end
                STATE_START: begin
                    fill_enable <= 1'b1;
                    state <= STATE_RUNNING;
                end
                STATE_RUNNING: begin
                    if (fill_done) begin
                        fill_enable <= 1'b0;
                        local_reset <= 1'b1; // Returns the engine to idle
                        state <= STATE_PREDONE;
                    end
                end
                STATE_PREDONE: begin
                    local_reset <= 1'b0;
                    done <= 1'b1;
                    state <= STATE_DONE;
                end
                STATE_DONE: begin
                    done <= 1'b0;
                    ready_for_data <= 1'b1;
                    x1_count <= COUNT_BITS'(COLUMN_BYTES - 1);
                    width_count <= COUNT_BITS'(COLUMN_BYTES - 1);
                    color_count <= SEL_BITS'(BYTES_PER_PIXEL - 1);
                    x1 <= '0;
                    width <= '0;
                    y1 <= '0;
                    height <= '0;
                    color <= '0;
                    state <= STATE_X1;
                end
                default: state <= STATE_X1;
            endcase
        end
    end

    control_subcmd_fillarea #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT),
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
    ) fillarea (
        .clk(clk),
        .reset(reset || local_reset),
        .enable(fill_enable),
        .x1(x1),
        .y1(y1),
        .width(width),
        .height(height),
        .color(color),
        .row(row),
        .column(column),
        .pixel(pixel),
        .data_out(data_out),
        .ram_write_enable(ram_write_enable),
        .done(fill_done)
    );
endmodule

//--- hw/control_subcmd_fillarea.sv
/* Fill engine that walks the clipped rectangle and writes one colour byte per cycle */
module control_subcmd_fillarea #(
    parameter int PIXEL_WIDTH = led_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT = led_pkg::PIXEL_HEIGHT,
    parameter int BYTES_PER_PIXEL = led_pkg::BYTES_PER_PIXEL
) (
    input  logic clk,
    input  logic reset,
    input  logic enable,
    input  logic [led_pkg::num_bytes_to_contain(
        led_pkg::num_column_address_bits(PIXEL_WIDTH) + 1)*8-1:0] x1,
    input  logic [7:0] y1,
    input  logic [led_pkg::num_bytes_to_contain(
        led_pkg::num_column_address_bits(PIXEL_WIDTH) + 1)*8-1:0] width,
    input  logic [7:0] height,
    input  logic [BYTES_PER_PIXEL*8-1:0] color,
    output logic [led_pkg::num_row_address_bits(PIXEL_HEIGHT)-1:0] row,
    output logic [led_pkg::num_column_address_bits(PIXEL_WIDTH)-1:0] column,
    output logic [led_pkg::num_pixel_select_bits(BYTES_PER_PIXEL)-1:0] pixel,
    output logic [7:0] data_out,
    output logic ram_write_enable,
    output logic done
);
    localparam int COLUMN_BITS = led_pkg::num_column_address_bits(PIXEL_WIDTH);
    localparam int ROW_BITS = led_pkg::num_row_address_bits(PIXEL_HEIGHT);
    localparam int SEL_BITS = led_pkg::num_pixel_select_bits(BYTES_PER_PIXEL);
    localparam int XS = led_pkg::num_bytes_to_contain(COLUMN_BITS + 1) * 8 + 1; // Sum width
    localparam int YS = 9;

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_WRITE,
        FILL_FINISHED
    } fillarea_state_t;

    fillarea_state_t state;
    logic [XS-1:0] x_sum;
    logic [XS-1:0] x_stop;
    logic [YS-1:0] y_sum;
    logic [YS-1:0] y_stop;
    logic empty;
    logic last_column;
    logic last_row;

    // End column and row are exclusive and capped at the panel edges
    always_comb begin
        x_sum = XS'(x1) + XS'(width);
        y_sum = YS'(y1) + YS'(height);
        x_stop = (x_sum > XS'(PIXEL_WIDTH)) ? XS'(PIXEL_WIDTH) : x_sum;
        y_stop = (y_sum > YS'(PIXEL_HEIGHT)) ? YS'(PIXEL_HEIGHT) : y_sum;
        empty = (XS'(x1) >= x_stop) || (YS'(y1) >= y_stop); // Also covers a start off the panel
        last_column = (XS'(column) + 1'b1) == x_stop;
        last_row = (YS'(row) + 1'b1) == y_stop;
    end

    assign data_out = color[pixel*8 +: 8];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FILL_IDLE;
            ram_write_enable <= 1'b0;
            done <= 1'b0;
            row <= '0;
            column <= '0;
            pixel <= '0;
        end else begin
            case (state)
                FILL_IDLE: begin
                    if (enable) begin
                        if (empty) begin
                            done <= 1'b1; // Nothing to draw
                            state <= FILL_FINISHED;
                        end else begin
                            row <= y1[ROW_BITS-1:0];
                            column <= x1[COLUMN_BITS-1:0];
                            pixel <= SEL_BITS'(BYTES_PER_PIXEL - 1);
                            ram_write_enable <= 1'b1;
                            state <= FILL_WRITE;
                        end
                    end
                end
                FILL_WRITE: begin
                    if (pixel != '0) begin
                        pixel <= pixel - 1'b1;
                    end else begin
                        pixel <= SEL_BITS'(BYTES_PER_PIXEL - 1);
                        if (!last_column) begin
                            column <= column + 1'b1;
                        end else begin
                            column <= x1[COLUMN_BITS-1:0];
                            if (!last_row) begin
                                row <= row + 1'b1;
                            end else begin
                                ram_write_enable <= 1'b0;
                                done <= 1'b1;
                                state <= FILL_FINISHED;
                            end
                        end
                    end
                end
                FILL_FINISHED: begin
                    done <= 1'b0; // Held here until the command resets us
                end
                default: state <= FILL_IDLE;
            endcase
        end
    end
endmodule

//--- hw/framebuffer_ram.sv
/* Byte-wide framebuffer with one synchronous write port and one synchronous read port */
module framebuffer_ram #(
    parameter int PIXEL_WIDTH = led_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT = led_pkg::PIXEL_HEIGHT,
    parameter int BYTES_PER_PIXEL = led_pkg::BYTES_PER_PIXEL
) (
    input  logic clk,
    input  logic [led_pkg::num_row_address_bits(PIXEL_HEIGHT)-1:0] row,
    input  logic [led_pkg::num_column_address_bits(PIXEL_WIDTH)-1:0] column,
    input  logic [led_pkg::num_pixel_select_bits(BYTES_PER_PIXEL)-1:0] pixel,
    input  logic [7:0] data_in,
    input  logic write_enable,
    input  logic [led_pkg::num_row_address_bits(PIXEL_HEIGHT)-1:0] rd_row,
    input  logic [led_pkg::num_column_address_bits(PIXEL_WIDTH)-1:0] rd_column,
    input  logic [led_pkg::num_pixel_select_bits(BYTES_PER_PIXEL)-1:0] rd_pixel,
    output logic [7:0] rd_data
);
    localparam int DEPTH = PIXEL_HEIGHT * PIXEL_WIDTH * BYTES_PER_PIXEL;
    localparam int ADDR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [7:0] mem [DEPTH];

    // Row-major layout with the pixel bytes of a column kept together
    function automatic logic [ADDR_BITS-1:0] byte_address(
        input int unsigned r,
        input int unsigned c,
        input int unsigned p
    );
        return ADDR_BITS'((r * PIXEL_WIDTH + c) * BYTES_PER_PIXEL + p);
    endfunction

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[byte_address(row, column, pixel)] <= data_in;
        end
        rd_data <= mem[byte_address(rd_row, rd_column, rd_pixel)];
    end
endmodule

//--- hw/led_panel_core.sv
/* Top level of the LED panel command path: dispatcher, fill command and framebuffer */
module led_panel_core #(
    parameter int PIXEL_WIDTH = led_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT = led_pkg::PIXEL_HEIGHT,
    parameter int BYTES_PER_PIXEL = led_pkg::BYTES_PER_PIXEL
) (
    input  logic clk,
    input  logic reset,
    input  logic [7:0] data_in,
    input  logic data_valid,
    output logic ready,
    output logic cmd_done,
    output logic cmd_error,
    input  logic [led_pkg::num_row_address_bits(PIXEL_HEIGHT)-1:0] rd_row,
    input  logic [led_pkg::num_column_address_bits(PIXEL_WIDTH)-1:0] rd_column,
    input  logic [led_pkg::num_pixel_select_bits(BYTES_PER_PIXEL)-1:0] rd_pixel,
    output logic [7:0] rd_data
);
    localparam int ROW_BITS = led_pkg::num_row_address_bits(PIXEL_HEIGHT);
    localparam int COLUMN_BITS = led_pkg::num_column_address_bits(PIXEL_WIDTH);
    localparam int SEL_BITS = led_pkg::num_pixel_select_bits(BYTES_PER_PIXEL);

    logic cmd_enable;
    logic fill_ready;
    logic [ROW_BITS-1:0] fb_row;
    logic [COLUMN_BITS-1:0] fb_column;
    logic [SEL_BITS-1:0] fb_pixel;
    logic [7:0] fb_data;
    logic fb_write_enable;

    command_dispatch dispatch (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .data_valid(data_valid),
        .fill_ready(fill_ready),
        .fill_done(cmd_done),
        .cmd_enable(cmd_enable),
        .ready(ready),
        .cmd_error(cmd_error)
    );

    control_cmd_fillrect #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT),
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
    ) fillrect (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .enable(cmd_enable),
        .row(fb_row),
        .column(fb_column),
        .pixel(fb_pixel),
        .data_out(fb_data),
        .ram_write_enable(fb_write_enable),
        .ready_for_data(fill_ready),
        .done(cmd_done)
    );

    framebuffer_ram #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT),
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
    ) framebuffer (
        .clk(clk),
        .row(fb_row),
        .column(fb_column),
        .pixel(fb_pixel),
        .data_in(fb_data),
        .write_enable(fb_write_enable),
        .rd_row(rd_row),
        .rd_column(rd_column),
        .rd_pixel(rd_pixel),
        .rd_data(rd_data)
    );
endmodule

//--- hw/led_pkg.sv
/* Panel size, derived address widths, and the opcode and dispatcher state types */
package led_pkg;
    function automatic int address_bits(input int count);
        return (count > 1) ? $clog2(count) : 1;
    endfunction

    function automatic int num_column_address_bits(input int pixel_width);
        return address_bits(pixel_width);
    endfunction

    function automatic int num_row_address_bits(input int pixel_height);
        return address_bits(pixel_height);
    endfunction

    function automatic int num_pixel_select_bits(input int bytes_per_pixel);
        return address_bits(bytes_per_pixel);
    endfunction

    function automatic int num_bytes_to_contain(input int bits);
        return (bits + 7) / 8;
    endfunction

    localparam int PIXEL_WIDTH = 64;
    localparam int PIXEL_HEIGHT = 32;
    localparam int BYTES_PER_PIXEL = 2;

    localparam int COLUMN_BITS = num_column_address_bits(PIXEL_WIDTH);
    localparam int ROW_BITS = num_row_address_bits(PIXEL_HEIGHT);
    localparam int PIXEL_SEL_BITS = num_pixel_select_bits(BYTES_PER_PIXEL);
    localparam int COLUMN_BYTES = num_bytes_to_contain(COLUMN_BITS + 1); // Holds a full-panel width

    typedef enum logic [7:0] {
        OP_NOP      = 8'h00,
        OP_FILLRECT = 8'h46
    } opcode_t;

    typedef enum logic {
        STATE_OPCODE,
        STATE_FORWARD
    } dispatch_state_t;
endpackage

//--- led_panel_core.f
+incdir+testbench
hw/led_pkg.sv
hw/framebuffer_ram.sv
hw/control_subcmd_fillarea.sv
hw/control_cmd_fillrect.sv
hw/command_dispatch.sv
hw/led_panel_core.sv
testbench/led_panel_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and decides the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module led_panel_core_tb -f led_panel_core.f -o led_panel_sim \
    && ./obj_dir/led_panel_sim > sim.log 2>&1 \
    || echo "Build or simulation run failed"
cat sim.log 2>/dev/null
grep -qx ">>> PASS" sim.log && echo "Result: pass" && exit 0 || { echo "Result: fail"; exit 1; }

//--- testbench/tb_model.svh
/* Testbench reference model: xorshift generator, expected panel image and fill rule */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [7:0] image [PIXEL_HEIGHT][PIXEL_WIDTH][BYTES_PER_PIXEL]; // Expected framebuffer bytes

function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state ^ (state << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
endfunction

// Writes the clipped rectangle with the first colour byte at the top pixel select
function automatic void fill_model(input int x1, input int y1, input int width,
                                   input int height, input logic [COLOR_BITS-1:0] color);
    int x_end;
    int y_end;
    x_end = (x1 + width > PIXEL_WIDTH) ? PIXEL_WIDTH : x1 + width;    // Exclusive end
    y_end = (y1 + height > PIXEL_HEIGHT) ? PIXEL_HEIGHT : y1 + height;
    for (int r = y1; r < y_end; r++) begin
        for (int c = x1; c < x_end; c++) begin
            for (int p = 0; p < BYTES_PER_PIXEL; p++) begin
                image[r][c][p] = color[p*8 +: 8];
            end
        end
    end
endfunction

`endif

//--- testbench/led_panel_core_tb.sv
/* Testbench for the LED panel core: fill commands, read-back sweeps, timeout and verdict */
module led_panel_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PIXEL_WIDTH = led_pkg::PIXEL_WIDTH;
    localparam int PIXEL_HEIGHT = led_pkg::PIXEL_HEIGHT;
    localparam int BYTES_PER_PIXEL = led_pkg::BYTES_PER_PIXEL;
    localparam int ROW_BITS = led_pkg::ROW_BITS;
    localparam int COLUMN_BITS = led_pkg::COLUMN_BITS;
    localparam int SEL_BITS = led_pkg::PIXEL_SEL_BITS;
    localparam int COLOR_BITS = BYTES_PER_PIXEL * 8;
    localparam int PANEL_BYTES = PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL;
    localparam int NUM_FILLS = 27;
    localparam int NUM_SWEEPS = 28;
    localparam int TIMEOUT_CYCLES = 4 * (NUM_FILLS + NUM_SWEEPS) * PANEL_BYTES;

    logic clk;
    logic reset;
    logic [7:0] data_in;
    logic data_valid;
    logic ready;
    logic cmd_done;
    logic cmd_error;
    logic [ROW_BITS-1:0] rd_row;
    logic [COLUMN_BITS-1:0] rd_column;
    logic [SEL_BITS-1:0] rd_pixel;
    logic [7:0] rd_data;
    logic [31:0] rng;
    logic sweep_active;
    logic pend_valid = 1'b0;
    logic [ROW_BITS-1:0] pend_row;
    logic [COLUMN_BITS-1:0] pend_column;
    logic [SEL_BITS-1:0] pend_pixel;
    logic [7:0] expected_data;
    int cycle_count = 0;
    int done_count = 0;
    int error_count = 0;

    `include "tb_model.svh"

    led_panel_core #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT),
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_failure(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cmd_done) done_count <= done_count + 1;
        if (cmd_error) error_count <= error_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            stop_on_failure($sformatf("Timeout: tests not finished after %0d cycles", cycle_count));
    end

    // Read address of the previous cycle, whose data shows on rd_data now
    always @(posedge clk) begin
        pend_valid <= sweep_active;
        pend_row <= rd_row;
        pend_column <= rd_column;
        pend_pixel <= rd_pixel;
    end

    always @(negedge clk) begin
        if (pend_valid) begin
            expected_data = image[pend_row][pend_column][pend_pixel];
            assert (rd_data === expected_data) else stop_on_failure($sformatf(
                "Error rd_data row %h column %h pixel %h expected %h actual %h",
                pend_row, pend_column, pend_pixel, expected_data, rd_data));
        end
    end

    function automatic int random_below(input int limit);
        rng = xorshift(rng);
        return int'(rng % 32'(limit));
    endfunction

    function automatic logic [COLOR_BITS-1:0] random_color();
        rng = xorshift(rng);
        return rng[COLOR_BITS-1:0];
    endfunction

    task automatic expect_ready(input logic level, input string when_text);
        assert (ready === level) else stop_on_failure($sformatf(
            "Error ready %s expected %h actual %h", when_text, level, ready));
    endtask

    task automatic send_byte(input logic [7:0] value);
        while (!ready) begin
            @(posedge clk);
            #10;
        end
        data_in = value;
        data_valid = 1'b1;
        @(posedge clk);
        #10;
        data_valid = 1'b0;
    endtask

    task automatic fill_rect(input int x1, input int y1, input int width, input int height,
                             input logic [COLOR_BITS-1:0] color);
        int start_done;
        start_done = done_count;
        send_byte(led_pkg::OP_FILLRECT);
        for (int i = led_pkg::COLUMN_BYTES - 1; i >= 0; i--) send_byte(8'(x1 >> (8 * i)));
        send_byte(8'(y1));
        for (int i = led_pkg::COLUMN_BYTES - 1; i >= 0; i--) send_byte(8'(width >> (8 * i)));
        send_byte(8'(height));
        for (int i = BYTES_PER_PIXEL - 1; i >= 0; i--) send_byte(color[i*8 +: 8]);
        while (!cmd_done) begin
            expect_ready(1'b0, "while the fill runs");
            rng = xorshift(rng);
            data_in = rng[7:0]; // Junk strobe that the busy core must drop
            data_valid = 1'b1;
            @(posedge clk);
            #10;
        end
        expect_ready(1'b0, "with cmd_done high");
        data_valid = 1'b0;
        @(posedge clk);
        #10;
        expect_ready(1'b1, "after cmd_done");
        assert (done_count == start_done + 1) else stop_on_failure($sformatf(
            "Error cmd_done count expected %h actual %h", start_done + 1, done_count));
        fill_model(x1, y1, width, height, color);
    endtask

    task automatic send_unknown_opcode(input logic [7:0] opcode);
        int start_done;
        int start_error;
        start_done = done_count;
        start_error = error_count;
        send_byte(opcode);
        assert (cmd_error === 1'b1) else stop_on_failure($sformatf(
            "Error cmd_error after opcode %h expected %h actual %h", opcode, 1'b1, cmd_error));
        repeat (4) begin
            @(posedge clk);
            #10;
        end
        assert (error_count == start_error + 1 && done_count == start_done) else
            stop_on_failure($sformatf("Error pulse counts cmd_error %h cmd_done %h expected %h %h",
                error_count - start_error, done_count - start_done, 1, 0));
    endtask

    task automatic sweep_framebuffer();
        for (int r = 0; r < PIXEL_HEIGHT; r++) begin
            for (int c = 0; c < PIXEL_WIDTH; c++) begin
                for (int p = 0; p < BYTES_PER_PIXEL; p++) begin
                    rd_row = ROW_BITS'(r);
                    rd_column = COLUMN_BITS'(c);
                    rd_pixel = SEL_BITS'(p);
                    sweep_active = 1'b1;
                    @(posedge clk);
                    #10;
                end
            end
        end
        sweep_active = 1'b0;
        @(posedge clk);
        #10;
    endtask

    initial begin
        int x1;
        int y1;
        int width;
        int height;
        reset = 1'b1;
        data_in = '0;
        data_valid = 1'b0;
        rd_row = '0;
        rd_column = '0;
        rd_pixel = '0;
        sweep_active = 1'b0;
        rng = 32'h971b;
        repeat (16) @(posedge clk);
        #10;
        reset = 1'b0;
        expect_ready(1'b1, "after reset");

        fill_rect(0, 0, PIXEL_WIDTH, PIXEL_HEIGHT, '0); // Gives the model a known image
        sweep_framebuffer();
        for (int i = 0; i < 20; i++) begin
            x1 = random_below(PIXEL_WIDTH);
            y1 = random_below(PIXEL_HEIGHT);
            width = 1 + random_below(PIXEL_WIDTH / 2);
            height = 1 + random_below(PIXEL_HEIGHT / 2);
            fill_rect(x1, y1, width, height, random_color());
            sweep_framebuffer();
        end

        // Right edge, both edges, then bottom edge
        fill_rect(PIXEL_WIDTH - 14, 20, 30, 8, random_color());
        sweep_framebuffer();
        fill_rect(PIXEL_WIDTH - 4, PIXEL_HEIGHT - 4, 200, 200, random_color());
        sweep_framebuffer();
        fill_rect(0, PIXEL_HEIGHT - 2, PIXEL_WIDTH, 10, random_color());
        sweep_framebuffer();

        fill_rect(10, 5, 0, 8, random_color());
        sweep_framebuffer();
        fill_rect(10, 5, 8, 0, random_color());
        sweep_framebuffer();

        send_unknown_opcode(8'ha5);
        sweep_framebuffer();
        fill_rect(3, 2, 12, 6, random_color());
        sweep_framebuffer();

        $display(">>> PASS");
        $finish;
    end
endmodule
